// ==== src.f ====
+incdir+src
src/cache_pkg.sv
src/cache_line_if.sv
src/cache_array.sv
src/cache_driver.sv
src/bus_interface_unit.sv
src/cache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mem_model.sv
testbench/cache_tb.sv

// ==== src/bus_interface_unit.sv ====
`default_nettype none

module bus_interface_unit (
    input  logic             clk,
    input  logic             n_rst,

    cache_line_if.biu        line,

    output logic             o_mem_en,
    output logic             o_mem_we,
    output cache_pkg::addr_t o_mem_addr,
    output cache_pkg::word_t o_mem_wdata,
    input  cache_pkg::word_t i_mem_rdata,
    input  logic             i_mem_ack
);

    import cache_pkg::*;

    localparam beat_t LAST_BEAT = beat_t'(LINE_WORDS - 1);

    beat_t                            beat_q;
    logic                             beat_ack;
    logic [LINE_WIDTH-DATA_WIDTH-1:0] fill_q;   // All words but the last

    assign beat_ack = line.en && i_mem_ack;

    // Beat address moves on after each acknowledge
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            beat_q <= '0;
        end else if (!line.en) begin
            beat_q <= '0;
        end else if (i_mem_ack) begin
            beat_q <= beat_q + 1'b1;   // Wraps for the next transfer
        end
    end

    // Fill words shift in from the top, word 0 ends up lowest
    always_ff @(posedge clk) begin
        if (beat_ack && !line.we) begin
            fill_q <= {i_mem_rdata, fill_q[LINE_WIDTH-DATA_WIDTH-1:DATA_WIDTH]};
        end
    end

    // Last word taken straight from the bus on the done cycle
    assign line.rdata = {i_mem_rdata, fill_q};
    assign line.done  = beat_ack && (beat_q == LAST_BEAT);
    assign line.busy  = line.en && !line.done;

    assign o_mem_en    = line.en;
    assign o_mem_we    = line.en && line.we;
    assign o_mem_addr  = {line.addr[ADDR_WIDTH-1:OFFSET_WIDTH], beat_q,
                          {WORD_OFFSET_WIDTH{1'b0}}};
    assign o_mem_wdata = line.wdata[beat_q*DATA_WIDTH +: DATA_WIDTH];

    // Memory only answers a request in flight
    a_ack_needs_en: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_mem_ack |-> o_mem_en
    );

endmodule

`default_nettype wire

// ==== src/cache_array.sv ====
`default_nettype none

module cache_array (
    input  logic               clk,
    input  logic               n_rst,

    input  logic               i_re,
    input  logic               i_we,
    input  logic               i_fe,
    input  cache_pkg::index_t  i_index,
    input  cache_pkg::offset_t i_offset,
    input  cache_pkg::tag_t    i_tag,
    input  cache_pkg::word_t   i_wdata,
    input  cache_pkg::line_t   i_fdata,

    output logic               o_hit,
    output logic               o_valid,
    output logic               o_dirty,
    output cache_pkg::tag_t    o_tag,
    output cache_pkg::line_t   o_vdata,
    output cache_pkg::word_t   o_rdata
);

    import cache_pkg::*;

    logic [INDEX_COUNT-1:0] valid_q;
    logic [INDEX_COUNT-1:0] dirty_q;
    tag_t                   tag_mem  [INDEX_COUNT];
    line_t                  data_mem [INDEX_COUNT];

    line_t                  sel_line;
    beat_t                  word_sel;
    logic                   tag_match;
    logic                   write_hit;

    assign word_sel  = i_offset[OFFSET_WIDTH-1:WORD_OFFSET_WIDTH];
    assign sel_line  = data_mem[i_index];
    assign tag_match = (tag_mem[i_index] == i_tag);

    assign o_valid   = valid_q[i_index];
    assign o_dirty   = dirty_q[i_index];
    assign o_tag     = tag_mem[i_index];
    assign o_vdata   = sel_line;
    assign o_rdata   = sel_line[word_sel*DATA_WIDTH +: DATA_WIDTH];
    assign o_hit     = (i_re || i_we) && o_valid && tag_match;
    assign write_hit = i_we && o_hit;

    // Line state
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_fe) begin
            valid_q[i_index] <= 1'b1;
            dirty_q[i_index] <= 1'b0;   // Fresh from memory
        end else if (write_hit) begin
            dirty_q[i_index] <= 1'b1;
        end
    end

    // Tags and data
    always_ff @(posedge clk) begin
        if (i_fe) begin
            tag_mem[i_index]  <= i_tag;
            data_mem[i_index] <= i_fdata;
        end else if (write_hit) begin
            data_mem[i_index][word_sel*DATA_WIDTH +: DATA_WIDTH] <= i_wdata;
        end
    end

    // A fill and a processor write never share a cycle
    a_no_we_with_fe: assert property (
        @(posedge clk) disable iff (!n_rst)
        !(i_we && i_fe)
    );

endmodule

`default_nettype wire

// ==== src/cache_driver.sv ====
`default_nettype none

module cache_driver (
    input  logic               clk,
    input  logic               n_rst,

    input  logic               i_re,
    input  logic               i_we,
    input  cache_pkg::addr_t   i_addr,
    input  cache_pkg::word_t   i_wdata,
    output cache_pkg::word_t   o_rdata,
    output logic               o_hit,
    output logic               o_busy,

    output logic               o_arr_re,
    output logic               o_arr_we,
    output logic               o_arr_fe,
    output cache_pkg::index_t  o_arr_index,
    output cache_pkg::offset_t o_arr_offset,
    output cache_pkg::tag_t    o_arr_tag,
    output cache_pkg::word_t   o_arr_wdata,
    output cache_pkg::line_t   o_arr_fdata,
    input  logic               i_arr_hit,
    input  logic               i_arr_valid,
    input  logic               i_arr_dirty,
    input  cache_pkg::tag_t    i_arr_tag,
    input  cache_pkg::line_t   i_arr_vdata,
    input  cache_pkg::word_t   i_arr_rdata,

    cache_line_if.driver       line
);

    import cache_pkg::*;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        MISS   = 2'b01,
        VICTIM = 2'b10
    } state_t;

    state_t  state_q;
    state_t  state_d;

    offset_t offset;
    index_t  index;
    tag_t    tag;
    logic    req;
    logic    fill_done;
    logic    victim;

    line_t   vdata_q;   // Old line, captured at fill
    addr_t   vaddr_q;

    assign offset    = i_addr[OFFSET_WIDTH-1:0];
    assign index     = i_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign tag       = i_addr[ADDR_WIDTH-1 -: TAG_WIDTH];

    assign req       = i_re || i_we;
    assign fill_done = line.done && (state_q == MISS);
    assign victim    = fill_done && i_arr_valid && i_arr_dirty;

    assign o_arr_re     = i_re;
    assign o_arr_we     = i_we && (state_q == IDLE);   // Held off during miss handling
    assign o_arr_fe     = fill_done;
    assign o_arr_index  = index;
    assign o_arr_offset = offset;
    assign o_arr_tag    = tag;
    assign o_arr_wdata  = i_wdata;
    assign o_arr_fdata  = line.rdata;

    assign o_rdata = i_arr_rdata;
    assign o_hit   = i_arr_hit;
    assign o_busy  = (state_q != IDLE);

    assign line.en    = (state_q != IDLE);
    assign line.we    = (state_q == VICTIM);
    assign line.addr  = (state_q == VICTIM) ? vaddr_q : {tag, index, {OFFSET_WIDTH{1'b0}}};
    assign line.wdata = vdata_q;

    // Array still holds the old line on this edge
    always_ff @(posedge clk) begin
        if (fill_done) begin
            vdata_q <= i_arr_vdata;
            vaddr_q <= {i_arr_tag, index, {OFFSET_WIDTH{1'b0}}};
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req && !i_arr_hit) begin
                    state_d = MISS;
                end
            end
            MISS: begin
                if (line.done) begin
                    state_d = victim ? VICTIM : IDLE;
                end
            end
            VICTIM: begin
                if (line.done) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // Request stays steady while beats are outstanding
    a_request_steady: assert property (
        @(posedge clk) disable iff (!n_rst)
        line.busy |=> (line.en && $stable(line.addr) && $stable(line.we))
    );

    // New line already in place and clean during write-back
    a_victim_after_fill: assert property (
        @(posedge clk) disable iff (!n_rst)
        (state_q == VICTIM) |-> (i_arr_valid && !i_arr_dirty && (i_arr_tag == tag))
    );

endmodule

`default_nettype wire

// ==== src/cache_line_if.sv ====
`default_nettype none

interface cache_line_if;

    import cache_pkg::*;

    logic  en;      // Held for whole transfer
    logic  we;      // Write-back when high, fill when low
    addr_t addr;    // Line aligned
    line_t wdata;
    line_t rdata;   // Complete on done cycle
    logic  done;
    logic  busy;

    modport driver (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  done,
        input  busy
    );

    modport biu (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output done,
        output busy
    );

endinterface

`default_nettype wire

// ==== src/cache_pkg.sv ====
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

    localparam int DATA_WIDTH        = `CACHE_DATA_WIDTH;
    localparam int ADDR_WIDTH        = `CACHE_ADDR_WIDTH;
    localparam int LINE_BYTES        = `CACHE_LINE_SIZE;
    localparam int WORD_BYTES        = DATA_WIDTH / 8;
    localparam int LINE_WORDS        = LINE_BYTES / WORD_BYTES;
    localparam int INDEX_COUNT       = `CACHE_SIZE / `CACHE_LINE_SIZE;
    localparam int OFFSET_WIDTH      = $clog2(LINE_BYTES);
    localparam int WORD_OFFSET_WIDTH = $clog2(WORD_BYTES);   // Byte within a word
    localparam int BEAT_WIDTH        = $clog2(LINE_WORDS);
    localparam int INDEX_WIDTH       = $clog2(INDEX_COUNT);
    localparam int TAG_WIDTH         = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int LINE_WIDTH        = LINE_BYTES * 8;

    typedef logic [DATA_WIDTH-1:0]   word_t;
    typedef logic [LINE_WIDTH-1:0]   line_t;    // Word 0 in low bits
    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [TAG_WIDTH-1:0]    tag_t;
    typedef logic [INDEX_WIDTH-1:0]  index_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;
    typedef logic [BEAT_WIDTH-1:0]   beat_t;

endpackage

`default_nettype wire

// ==== src/cache_settings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Processor and memory word width in bits
`define CACHE_DATA_WIDTH 32

// Byte address width
`define CACHE_ADDR_WIDTH 16

// Data storage in bytes
`define CACHE_SIZE 256

// Bytes per line
`define CACHE_LINE_SIZE 16

`endif

// ==== src/cache_top.sv ====
`default_nettype none

module cache_top (
    input  logic             clk,
    input  logic             n_rst,

    input  logic             i_re,
    input  logic             i_we,
    input  cache_pkg::addr_t i_addr,
    input  cache_pkg::word_t i_wdata,
    output cache_pkg::word_t o_rdata,
    output logic             o_hit,
    output logic             o_busy,

    output logic             o_mem_en,
    output logic             o_mem_we,
    output cache_pkg::addr_t o_mem_addr,
    output cache_pkg::word_t o_mem_wdata,
    input  cache_pkg::word_t i_mem_rdata,
    input  logic             i_mem_ack
);

    import cache_pkg::*;

    logic    arr_re;
    logic    arr_we;
    logic    arr_fe;
    index_t  arr_index;
    offset_t arr_offset;
    tag_t    arr_tag;
    word_t   arr_wdata;
    line_t   arr_fdata;
    logic    arr_hit;
    logic    arr_valid;
    logic    arr_dirty;
    tag_t    arr_tag_out;
    line_t   arr_vdata;
    word_t   arr_rdata;

    cache_line_if line_bus ();

    cache_driver u_driver (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_re         (i_re),
        .i_we         (i_we),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .o_rdata      (o_rdata),
        .o_hit        (o_hit),
        .o_busy       (o_busy),
        .o_arr_re     (arr_re),
        .o_arr_we     (arr_we),
        .o_arr_fe     (arr_fe),
        .o_arr_index  (arr_index),
        .o_arr_offset (arr_offset),
        .o_arr_tag    (arr_tag),
        .o_arr_wdata  (arr_wdata),
        .o_arr_fdata  (arr_fdata),
        .i_arr_hit    (arr_hit),
        .i_arr_valid  (arr_valid),
        .i_arr_dirty  (arr_dirty),
        .i_arr_tag    (arr_tag_out),
        .i_arr_vdata  (arr_vdata),
        .i_arr_rdata  (arr_rdata),
        .line         (line_bus.driver)
    );

    cache_array u_array (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_re     (arr_re),
        .i_we     (arr_we),
        .i_fe     (arr_fe),
        .i_index  (arr_index),
        .i_offset (arr_offset),
        .i_tag    (arr_tag),
        .i_wdata  (arr_wdata),
        .i_fdata  (arr_fdata),
        .o_hit    (arr_hit),
        .o_valid  (arr_valid),
        .o_dirty  (arr_dirty),
        .o_tag    (arr_tag_out),
        .o_vdata  (arr_vdata),
        .o_rdata  (arr_rdata)
    );

    bus_interface_unit u_biu (
        .clk         (clk),
        .n_rst       (n_rst),
        .line        (line_bus.biu),
        .o_mem_en    (o_mem_en),
        .o_mem_we    (o_mem_we),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .i_mem_rdata (i_mem_rdata),
        .i_mem_ack   (i_mem_ack)
    );

endmodule

`default_nettype wire

// ==== testbench/cache_tb.sv ====
`default_nettype none

module cache_tb;

    import cache_pkg::*;

    localparam logic [31:0] SEED         = 32'h8787453e;
    localparam int          NUM_REQUESTS = 600;
    localparam int          CYCLES_EACH  = 40;
    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 4;
    localparam int          TIMEOUT      = (NUM_REQUESTS * CYCLES_EACH + 4 * RESET_CYCLES)
                                           * CLK_PERIOD;
    localparam int          MEM_WORDS    = 2 ** (ADDR_WIDTH - WORD_OFFSET_WIDTH);

    logic  clk;
    logic  n_rst;
    logic  re;
    logic  we;
    addr_t addr;
    word_t wdata;
    word_t rdata;
    logic  hit;
    logic  busy;
    logic  mem_en;
    logic  mem_we;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_ack;

    word_t  ref_mem     [MEM_WORDS];   // What the processor should see
    tag_t   model_tag   [INDEX_COUNT];
    logic   model_valid [INDEX_COUNT];
    logic   model_dirty [INDEX_COUNT];

    addr_t  beat_addr [$];
    logic   beat_we   [$];
    word_t  beat_data [$];

    integer seed;
    int     error_count;
    int     done_count;
    int     hit_count;
    int     fill_count;
    int     wb_count;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .o_clk   (clk),
        .o_n_rst (n_rst)
    );

    tb_mem_model #(.SEED(SEED)) u_mem (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_en    (mem_en),
        .i_we    (mem_we),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata),
        .o_ack   (mem_ack)
    );

    cache_top i_dut (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_re        (re),
        .i_we        (we),
        .i_addr      (addr),
        .i_wdata     (wdata),
        .o_rdata     (rdata),
        .o_hit       (hit),
        .o_busy      (busy),
        .o_mem_en    (mem_en),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata),
        .i_mem_ack   (mem_ack)
    );

    // Log every acknowledged beat
    always @(negedge clk) begin
        if (mem_en && mem_ack) begin
            beat_addr.push_back(mem_addr);
            beat_we.push_back(mem_we);
            beat_data.push_back(mem_wdata);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s at %0t: expected %h, actual %h",
                     name, $time, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_idle_outputs(input string name);
        check_value({name, "_busy"}, 0, busy);
        check_value({name, "_hit"}, 0, hit);
        check_value({name, "_mem_en"}, 0, mem_en);
        check_value({name, "_mem_we"}, 0, mem_we);
    endtask

    task automatic print_summary();
        $display("Requests %0d, hits %0d, fills %0d, write-backs %0d, errors %0d",
                 done_count, hit_count, fill_count, wb_count, error_count);
    endtask

    task automatic run_request(input logic is_write, input addr_t req_addr,
                               input word_t req_wdata);
        index_t idx;
        tag_t   tg;
        tag_t   old_tag;
        logic   exp_hit;
        logic   exp_victim;
        logic   saw_busy;
        logic   saw_en;
        logic   served;
        addr_t  new_base;
        addr_t  old_base;
        int     n;
        int     k;
        idx        = req_addr[OFFSET_WIDTH +: INDEX_WIDTH];
        tg         = req_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
        old_tag    = model_tag[idx];
        exp_hit    = model_valid[idx] && (old_tag == tg);
        exp_victim = !exp_hit && model_valid[idx] && model_dirty[idx];
        new_base   = {tg, idx, {OFFSET_WIDTH{1'b0}}};
        old_base   = {old_tag, idx, {OFFSET_WIDTH{1'b0}}};
        saw_busy   = 1'b0;
        saw_en     = 1'b0;
        served     = 1'b0;

        @(posedge clk);
        beat_addr.delete();
        beat_we.delete();
        beat_data.delete();
        re    <= !is_write;
        we    <= is_write;
        addr  <= req_addr;
        wdata <= req_wdata;
        while (!served) begin
            @(negedge clk);
            saw_busy = saw_busy | busy;
            saw_en   = saw_en | mem_en;
            served   = hit && !busy;
        end
        if (!is_write) begin
            check_value("read_data", ref_mem[req_addr[ADDR_WIDTH-1:2]], rdata);
        end
        @(posedge clk);   // Write hit lands on this edge
        re <= 1'b0;
        we <= 1'b0;

        if (exp_hit) begin
            hit_count++;
            check_value("hit_busy", 0, saw_busy);
            check_value("hit_mem_en", 0, saw_en);
        end else begin
            n = exp_victim ? 2 * LINE_WORDS : LINE_WORDS;
            check_value("miss_busy", 1, saw_busy);
            check_value("beat_count", n, beat_addr.size());
            if (beat_addr.size() == n) begin
                for (k = 0; k < LINE_WORDS; k++) begin
                    check_value("fill_addr", new_base + 4 * k, beat_addr[k]);
                    check_value("fill_we", 0, beat_we[k]);
                end
                for (k = 0; exp_victim && k < LINE_WORDS; k++) begin
                    check_value("wb_addr", old_base + 4 * k, beat_addr[LINE_WORDS + k]);
                    check_value("wb_we", 1, beat_we[LINE_WORDS + k]);
                    check_value("wb_data", ref_mem[old_base[ADDR_WIDTH-1:2] + k],
                                beat_data[LINE_WORDS + k]);
                end
            end
            fill_count++;
            wb_count += exp_victim;
            model_tag[idx]   = tg;
            model_valid[idx] = 1'b1;
            model_dirty[idx] = 1'b0;
        end
        if (is_write) begin
            model_dirty[idx]                  = 1'b1;
            ref_mem[req_addr[ADDR_WIDTH-1:2]] = req_wdata;
        end
        done_count++;
    endtask

    // Words of dirty cached lines are allowed to be stale in memory
    task automatic check_final_memory();
        int     w;
        addr_t  a;
        index_t idx;
        tag_t   tg;
        for (w = 0; w < MEM_WORDS; w++) begin
            a   = addr_t'(w << 2);
            idx = a[OFFSET_WIDTH +: INDEX_WIDTH];
            tg  = a[ADDR_WIDTH-1 -: TAG_WIDTH];
            if (!(model_valid[idx] && model_dirty[idx] && model_tag[idx] == tg)) begin
                check_value($sformatf("final_mem[%h]", a), ref_mem[w], u_mem.mem[w]);
            end
        end
    endtask

    initial begin
        int          r;
        int          i;
        logic [31:0] rnd;
        tag_t        tg;
        re          <= 1'b0;
        we          <= 1'b0;
        addr        <= '0;
        wdata       <= '0;
        seed        = SEED;
        error_count = 0;
        done_count  = 0;
        hit_count   = 0;
        fill_count  = 0;
        wb_count    = 0;
        for (i = 0; i < INDEX_COUNT; i++) begin
            model_tag[i]   = '0;
            model_valid[i] = 1'b0;
            model_dirty[i] = 1'b0;
        end

        @(negedge clk);
        check_idle_outputs("in_reset");
        while (n_rst !== 1'b1) @(negedge clk);
        for (i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = u_mem.mem[i];   // Start from the preloaded image
        end
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs("after_reset");
        end

        for (r = 0; r < NUM_REQUESTS; r++) begin
            rnd = $random(seed);
            tg  = {rnd[3:1], 5'h0a};   // 8 distinct tags
            run_request(rnd[0], {tg, rnd[7:4], rnd[9:8], 2'b00}, $random(seed));
        end

        check_final_memory();
        print_summary();
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the cache stopped answering after %0d of %0d requests",
                 done_count, NUM_REQUESTS);
        error_count++;
        print_summary();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_n_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial begin
        o_n_rst <= 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_n_rst <= 1'b1;   // Released on a clock edge
    end

endmodule

`default_nettype wire

// ==== testbench/tb_mem_model.sv ====
`default_nettype none

module tb_mem_model #(
    parameter logic [31:0] SEED = 32'h8787453e
) (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             i_en,
    input  logic             i_we,
    input  cache_pkg::addr_t i_addr,
    input  cache_pkg::word_t i_wdata,
    output cache_pkg::word_t o_rdata,
    output logic             o_ack
);

    import cache_pkg::*;

    localparam int WORDS = 2 ** (ADDR_WIDTH - WORD_OFFSET_WIDTH);

    word_t                                 mem [WORDS];
    logic [ADDR_WIDTH-WORD_OFFSET_WIDTH-1:0] word_idx;
    integer                                seed;
    int                                    fill_idx;
    int                                    draw;
    int                                    delay_cnt;
    logic                                  waiting;
    logic                                  fire;

    assign word_idx = i_addr[ADDR_WIDTH-1:WORD_OFFSET_WIDTH];

    // Random contents mixed with the word address
    initial begin
        seed = SEED;
        for (fill_idx = 0; fill_idx < WORDS; fill_idx++) begin
            mem[fill_idx] = $random(seed) ^ (fill_idx * 32'h00010001);
        end
    end

    always @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            o_ack     <= 1'b0;
            o_rdata   <= '0;
            waiting   <= 1'b0;
            delay_cnt <= 0;
        end else begin
            fire = 1'b0;
            if (o_ack) begin
                o_ack   <= 1'b0;   // One-cycle pulse
                waiting <= 1'b0;
            end else if (i_en && !waiting) begin
                draw = $random(seed) & 3;   // 0 to 3 cycles of delay
                if (draw == 0) begin
                    fire = 1'b1;
                end else begin
                    waiting   <= 1'b1;
                    delay_cnt <= draw - 1;
                end
            end else if (i_en) begin
                if (delay_cnt == 0) begin
                    fire = 1'b1;
                end else begin
                    delay_cnt <= delay_cnt - 1;
                end
            end
            if (fire) begin
                o_ack   <= 1'b1;
                o_rdata <= mem[word_idx];
                if (i_we) begin
                    mem[word_idx] = i_wdata;
                end
            end
        end
    end

endmodule

`default_nettype wire
